// ==== bp_btb.sv ====
module bp_btb import bp_pkg::*; (
    input  logic    clk_i,
    input  bp_idx_t rd_idx_i,
    output pc_t     rd_target_o,
    input  logic    clear_i,
    input  bp_idx_t clear_idx_i,
    bp_update_if.btb upd
);

    pc_t  tgt_mem [BP_ENTRIES];
    logic wr_en;

    assign rd_target_o = tgt_mem[rd_idx_i];

    // only a taken branch that missed needs a new target
    // (covers both wrong direction and wrong target)
    assign wr_en = upd.upd_valid & upd.upd_taken & upd.upd_mispredict;

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            tgt_mem[clear_idx_i] <= '0;
        end else if (wr_en) begin
            tgt_mem[upd.upd_idx_btb] <= upd.upd_target;
        end
    end

endmodule

// ==== bp_chk.sv ====
module bp_chk import bp_pkg::*; (
    input logic clk_i,
    input logic rst_i,
    input logic advance_i,
    input logic redirect_i,
    input fix_e fix_i,
    input logic d_valid_i,
    input logic ex_valid_i,
    input pc_t  d_pc_i,
    input pc_t  ex_pc_i
);

    int err_cnt = 0;

    // a retired correction leaves nothing to correct in the next cycle
    a_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
        (redirect_i && advance_i) |=> (!redirect_i && fix_i == FIX_NONE))
        else begin
            $error("correction still reported after it retired");
            err_cnt++;
        end

    // a correction that advances flushes both stages
    a_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        (redirect_i && advance_i) |=> (!d_valid_i && !ex_valid_i))
        else begin
            $error("stage still valid after a correction");
            err_cnt++;
        end

    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !advance_i |=> ($stable(d_valid_i) && $stable(ex_valid_i)
                        && $stable(d_pc_i) && $stable(ex_pc_i)))
        else begin
            $error("stage changed while advance was low");
            err_cnt++;
        end

endmodule

bind bp_resolve_pipe bp_chk chk_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .advance_i  (advance_i),
    .redirect_i (redirect_o),
    .fix_i      (fix_o),
    .d_valid_i  (d_valid),
    .ex_valid_i (ex_valid),
    .d_pc_i     (d_pc),
    .ex_pc_i    (ex_pc)
);

// ==== bp_history.sv ====
module bp_history import bp_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   advance_i,
    input  logic   spec_push_i,
    input  logic   spec_bit_i,
    output ghist_t spec_hist_o,
    bp_update_if.history upd
);

    ghist_t spec_q;
    ghist_t commit_q;
    ghist_t commit_next;

    // committed history with the resolved outcome shifted in
    assign commit_next = {commit_q[GHIST_W-2:0], upd.upd_taken};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spec_q   <= '0;
            commit_q <= '0;
        end else begin
            if (upd.upd_valid) begin
                commit_q <= commit_next;
            end
            // repair wins, the branch at fetch is flushed anyway
            if (upd.upd_valid && upd.upd_mispredict) begin
                spec_q <= commit_next;
            end else if (advance_i && spec_push_i) begin
                spec_q <= {spec_q[GHIST_W-2:0], spec_bit_i};
            end
        end
    end

    assign spec_hist_o = spec_q;

endmodule

// ==== bp_init_fsm.sv ====
module bp_init_fsm import bp_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    output logic    clear_o,
    output bp_idx_t clear_idx_o,
    output logic    ready_o
);

    init_state_e state_q;
    bp_idx_t     idx_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= BP_CLEAR;
            idx_q   <= '0;
        end else begin
            case (state_q)
                BP_CLEAR: begin
                    // one entry per cycle, leave after the last one
                    idx_q <= idx_q + bp_idx_t'(1);
                    if (idx_q == bp_idx_t'(BP_ENTRIES - 1)) begin
                        state_q <= BP_RUN;
                    end
                end
                BP_RUN: begin
                    state_q <= BP_RUN;
                end
                default: begin
                    state_q <= BP_CLEAR;
                end
            endcase
        end
    end

    assign clear_o     = (state_q == BP_CLEAR);
    assign clear_idx_o = idx_q;
    // predictions only count once every entry is known
    assign ready_o     = (state_q == BP_RUN);

endmodule

// ==== bp_monitor.sv ====
module bp_monitor import bp_pkg::*; (
    input  logic         clk_i,
    input  logic         ready_i,
    input  logic         pred_taken_i,
    input  pc_t          pred_target_i,
    input  fix_e         fix_i,
    input  logic         redirect_i,
    input  pc_t          ex_pc_i,
    input  logic         chk_pred_i,
    input  logic         chk_fix_i,
    input  logic         chk_idle_i,
    input  logic         test_end_i,
    input  logic [127:0] name_i,
    input  logic         exp_ready_i,
    input  logic         exp_jal_i,
    input  logic         exp_pred_i,
    input  pc_t          exp_pc_i,
    input  pc_t          exp_target_i,
    input  fix_e         exp_fix_i,
    output int           pass_cnt_o,
    output int           fail_cnt_o
);

    int   pass_cnt = 0;
    int   fail_cnt = 0;
    logic test_bad = 1'b0;
    logic exp_redirect;

    assign exp_redirect = (exp_fix_i != FIX_NONE);

    // sample mid-cycle once inputs have settled
    always @(negedge clk_i) begin
        if (chk_pred_i) begin
            if (ready_i !== exp_ready_i) begin
                $display("mismatch %0s ready_o expected %0b actual %0b",
                         name_i, exp_ready_i, ready_i);
                test_bad = 1'b1;
            end
            if (pred_taken_i !== exp_pred_i) begin
                $display("mismatch %0s pred_taken_o expected %0b actual %0b",
                         name_i, exp_pred_i, pred_taken_i);
                test_bad = 1'b1;
            end
            if (exp_jal_i && pred_target_i !== exp_target_i) begin
                $display("mismatch %0s pred_target_o expected %h actual %h",
                         name_i, exp_target_i, pred_target_i);
                test_bad = 1'b1;
            end
        end
        // entry still stalled in decode
        if (chk_idle_i) begin
            if (fix_i !== FIX_NONE) begin
                $display("mismatch %0s fix_o before execute expected FIX_NONE actual %s",
                         name_i, fix_i.name());
                test_bad = 1'b1;
            end
            if (redirect_i !== 1'b0) begin
                $display("mismatch %0s redirect_o before execute expected 0 actual %0b",
                         name_i, redirect_i);
                test_bad = 1'b1;
            end
        end
        if (chk_fix_i) begin
            if (ex_pc_i !== exp_pc_i) begin
                $display("mismatch %0s ex_pc_o expected %h actual %h",
                         name_i, exp_pc_i, ex_pc_i);
                test_bad = 1'b1;
            end
            if (fix_i !== exp_fix_i) begin
                $display("mismatch %0s fix_o expected %s actual %s",
                         name_i, exp_fix_i.name(), fix_i.name());
                test_bad = 1'b1;
            end
            if (redirect_i !== exp_redirect) begin
                $display("mismatch %0s redirect_o expected %0b actual %0b",
                         name_i, exp_redirect, redirect_i);
                test_bad = 1'b1;
            end
        end
        if (test_end_i) begin
            if (test_bad) begin
                $display("test %0s: failed", name_i);
                fail_cnt++;
            end else begin
                $display("test %0s: ok", name_i);
                pass_cnt++;
            end
            test_bad = 1'b0;
        end
    end

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

endmodule

// ==== bp_pht.sv ====
module bp_pht import bp_pkg::*; (
    input  logic    clk_i,
    input  bp_idx_t rd_idx_i,
    output ctr_t    rd_ctr_o,
    input  logic    clear_i,
    input  bp_idx_t clear_idx_i,
    bp_update_if.pht upd
);

    ctr_t ctr_mem [BP_ENTRIES];
    ctr_t upd_cur;
    ctr_t upd_next;

    // predict side reads in the same cycle
    assign rd_ctr_o = ctr_mem[rd_idx_i];

    assign upd_cur = ctr_mem[upd.upd_idx_pht];

    // saturating step toward the actual outcome
    always_comb begin
        upd_next = upd_cur;
        if (upd.upd_taken) begin
            if (upd_cur != CTR_MAX) begin
                upd_next = upd_cur + ctr_t'(1);
            end
        end else begin
            if (upd_cur != CTR_MIN) begin
                upd_next = upd_cur - ctr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            ctr_mem[clear_idx_i] <= CTR_MIN;
        end else if (upd.upd_valid) begin
            ctr_mem[upd.upd_idx_pht] <= upd_next;
        end
    end

endmodule

// ==== bp_pkg.sv ====
package bp_pkg;

    // table geometry
    localparam int BP_ENTRIES = 32;
    localparam int BP_IDX_W   = 5;
    localparam int GHIST_W    = 7;

    // instruction address, halfword aligned
    typedef logic [18:1]         pc_t;
    typedef logic [BP_IDX_W-1:0] bp_idx_t;
    typedef logic [GHIST_W-1:0]  ghist_t;
    typedef logic [1:0]          ctr_t;

    // saturation limits of the direction counters
    localparam ctr_t CTR_MIN = 2'b00;
    localparam ctr_t CTR_MAX = 2'b11;

    // correction reported at execute
    typedef enum logic [1:0] {
        FIX_NONE      = 2'd0,
        // predicted taken, was not taken
        FIX_NOT_TAKEN = 2'd1,
        // predicted not taken, was taken
        FIX_TAKEN     = 2'd2,
        // taken as predicted, wrong target
        FIX_TARGET    = 2'd3
    } fix_e;

    typedef enum logic {
        BP_CLEAR = 1'b0,
        BP_RUN   = 1'b1
    } init_state_e;

endpackage

// ==== bp_resolve_pipe.sv ====
module bp_resolve_pipe import bp_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    advance_i,
    input  logic    f_valid_i,
    input  logic    f_is_branch_i,
    input  logic    f_pred_taken_i,
    input  pc_t     f_pc_i,
    input  pc_t     f_pred_target_i,
    input  bp_idx_t f_pht_idx_i,
    input  logic    resolve_taken_i,
    input  pc_t     resolve_target_i,
    output fix_e    fix_o,
    output logic    redirect_o,
    output pc_t     ex_pc_o,
    bp_update_if.driver upd
);

    // decode stage
    logic    d_valid;
    logic    d_is_branch;
    logic    d_pred_taken;
    pc_t     d_pc;
    pc_t     d_pred_target;
    bp_idx_t d_pht_idx;

    // execute stage
    logic    ex_valid;
    logic    ex_is_branch;
    logic    ex_pred_taken;
    pc_t     ex_pc;
    pc_t     ex_pred_target;
    bp_idx_t ex_pht_idx;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            d_valid  <= 1'b0;
            ex_valid <= 1'b0;
        end else if (advance_i) begin
            if (redirect_o) begin
                // flush everything younger than the correction
                d_valid  <= 1'b0;
                ex_valid <= 1'b0;
            end else begin
                d_valid  <= f_valid_i;
                ex_valid <= d_valid;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            d_is_branch    <= f_is_branch_i;
            d_pred_taken   <= f_pred_taken_i;
            d_pc           <= f_pc_i;
            d_pred_target  <= f_pred_target_i;
            d_pht_idx      <= f_pht_idx_i;
            ex_is_branch   <= d_is_branch;
            ex_pred_taken  <= d_pred_taken;
            ex_pc          <= d_pc;
            ex_pred_target <= d_pred_target;
            ex_pht_idx     <= d_pht_idx;
        end
    end

    // compare prediction with the resolved outcome
    always_comb begin
        fix_o = FIX_NONE;
        if (ex_valid) begin
            if (ex_pred_taken && !resolve_taken_i) begin
                fix_o = FIX_NOT_TAKEN;
            end else if (!ex_pred_taken && resolve_taken_i) begin
                fix_o = FIX_TAKEN;
            end else if (ex_pred_taken && (resolve_target_i != ex_pred_target)) begin
                fix_o = FIX_TARGET;
            end
        end
    end

    assign redirect_o = (fix_o != FIX_NONE);
    assign ex_pc_o    = ex_pc;

    // train only conditional branches, at the edge that retires them
    assign upd.upd_valid      = ex_valid & ex_is_branch & advance_i;
    assign upd.upd_idx_pht    = ex_pht_idx;
    assign upd.upd_idx_btb    = ex_pc[5:1];
    assign upd.upd_taken      = resolve_taken_i;
    assign upd.upd_target     = resolve_target_i;
    assign upd.upd_mispredict = redirect_o;

endmodule

// ==== bp_update_if.sv ====
interface bp_update_if import bp_pkg::*; ();

    // training bundle, one per retired branch
    logic    upd_valid;
    bp_idx_t upd_idx_pht;
    bp_idx_t upd_idx_btb;
    logic    upd_taken;
    pc_t     upd_target;
    logic    upd_mispredict;

    modport driver (
        output upd_valid, upd_idx_pht, upd_idx_btb, upd_taken, upd_target, upd_mispredict
    );

    modport pht (
        input upd_valid, upd_idx_pht, upd_taken
    );

    modport btb (
        input upd_valid, upd_idx_btb, upd_taken, upd_target, upd_mispredict
    );

    modport history (
        input upd_valid, upd_taken, upd_mispredict
    );

endinterface

// ==== branch_predictor.sv ====
module branch_predictor import bp_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic stall_i,
    input  logic fetch_valid_i,
    input  logic is_branch_i,
    input  logic is_jal_i,
    input  pc_t  pc_i,
    input  pc_t  imm_i,
    output logic pred_taken_o,
    output pc_t  pred_target_o,
    input  logic resolve_taken_i,
    input  pc_t  resolve_target_i,
    output fix_e fix_o,
    output logic redirect_o,
    output pc_t  ex_pc_o,
    output logic ready_o
);

    logic    clear;
    bp_idx_t clear_idx;
    logic    ready;
    logic    advance;
    ghist_t  spec_hist;
    bp_idx_t pht_rd_idx;
    ctr_t    pht_ctr;
    pc_t     btb_target;
    logic    f_valid;
    logic    spec_push;

    bp_update_if upd_if ();

    bp_init_fsm init_fsm_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .clear_o     (clear),
        .clear_idx_o (clear_idx),
        .ready_o     (ready)
    );

    // gshare hash of pc and speculative history
    assign pht_rd_idx = pc_i[5:1] ^ spec_hist[BP_IDX_W-1:0];

    bp_pht pht_i (
        .clk_i       (clk_i),
        .rd_idx_i    (pht_rd_idx),
        .rd_ctr_o    (pht_ctr),
        .clear_i     (clear),
        .clear_idx_i (clear_idx),
        .upd         (upd_if)
    );

    bp_btb btb_i (
        .clk_i       (clk_i),
        .rd_idx_i    (pc_i[5:1]),
        .rd_target_o (btb_target),
        .clear_i     (clear),
        .clear_idx_i (clear_idx),
        .upd         (upd_if)
    );

    // stages and history freeze on stall and during clearing
    assign advance   = ~stall_i & ready;
    assign f_valid   = fetch_valid_i & (is_branch_i | is_jal_i);
    assign spec_push = fetch_valid_i & is_branch_i;

    assign pred_taken_o  = ready & (is_jal_i | (is_branch_i & pht_ctr[1]));
    assign pred_target_o = is_jal_i ? (pc_i + imm_i) : btb_target;

    bp_history history_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .advance_i   (advance),
        .spec_push_i (spec_push),
        .spec_bit_i  (pred_taken_o),
        .spec_hist_o (spec_hist),
        .upd         (upd_if)
    );

    bp_resolve_pipe resolve_pipe_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .advance_i        (advance),
        .f_valid_i        (f_valid),
        .f_is_branch_i    (is_branch_i),
        .f_pred_taken_i   (pred_taken_o),
        .f_pc_i           (pc_i),
        .f_pred_target_i  (pred_target_o),
        .f_pht_idx_i      (pht_rd_idx),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .fix_o            (fix_o),
        .redirect_o       (redirect_o),
        .ex_pc_o          (ex_pc_o),
        .upd              (upd_if)
    );

    assign ready_o = ready;

endmodule

// ==== build.f ====
bp_pkg.sv
bp_update_if.sv
bp_init_fsm.sv
bp_pht.sv
bp_btb.sv
bp_history.sv
bp_resolve_pipe.sv
branch_predictor.sv
bp_monitor.sv
bp_chk.sv
tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_branch_predictor -o sim_bp &&
./obj_dir/sim_bp > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// ==== tb_branch_predictor.sv ====
module tb_branch_predictor import bp_pkg::*; ();

    localparam int N_TESTS = 15;

    logic clk;
    logic rst;
    logic stall;
    logic fetch_valid;
    logic is_branch;
    logic is_jal;
    pc_t  pc;
    pc_t  imm;
    logic pred_taken;
    pc_t  pred_target;
    logic resolve_taken;
    pc_t  resolve_target;
    fix_e fix;
    logic redirect;
    pc_t  ex_pc;
    logic ready;

    // strobes and expected values for the monitor
    logic         chk_pred;
    logic         chk_fix;
    logic         chk_idle;
    logic         test_end;
    logic [127:0] cur_name;
    logic         cur_ready;
    logic         cur_jal;
    logic         cur_pred;
    pc_t          cur_pc;
    pc_t          cur_target;
    fix_e         cur_fix;
    int           pass_cnt;
    int           fail_cnt;
    logic         timed_out;

    // stimulus table
    logic [127:0] t_name   [N_TESTS];
    pc_t          t_pc     [N_TESTS];
    pc_t          t_imm    [N_TESTS];
    logic         t_jal    [N_TESTS];
    logic         t_taken  [N_TESTS];
    pc_t          t_target [N_TESTS];
    int           t_stall  [N_TESTS];
    logic         t_pred   [N_TESTS];
    fix_e         t_fix    [N_TESTS];

    branch_predictor branch_predictor_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .stall_i          (stall),
        .fetch_valid_i    (fetch_valid),
        .is_branch_i      (is_branch),
        .is_jal_i         (is_jal),
        .pc_i             (pc),
        .imm_i            (imm),
        .pred_taken_o     (pred_taken),
        .pred_target_o    (pred_target),
        .resolve_taken_i  (resolve_taken),
        .resolve_target_i (resolve_target),
        .fix_o            (fix),
        .redirect_o       (redirect),
        .ex_pc_o          (ex_pc),
        .ready_o          (ready)
    );

    bp_monitor monitor_i (
        .clk_i         (clk),
        .ready_i       (ready),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .fix_i         (fix),
        .redirect_i    (redirect),
        .ex_pc_i       (ex_pc),
        .chk_pred_i    (chk_pred),
        .chk_fix_i     (chk_fix),
        .chk_idle_i    (chk_idle),
        .test_end_i    (test_end),
        .name_i        (cur_name),
        .exp_ready_i   (cur_ready),
        .exp_jal_i     (cur_jal),
        .exp_pred_i    (cur_pred),
        .exp_pc_i      (cur_pc),
        .exp_target_i  (cur_target),
        .exp_fix_i     (cur_fix),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt)
    );

    always #50 clk = ~clk;

    task automatic add_test(input int i, input logic [127:0] name, input pc_t p,
                            input pc_t im, input logic jal, input logic taken,
                            input pc_t target, input int stall_cycles,
                            input logic pred, input fix_e fx);
        t_name[i]   = name;
        t_pc[i]     = p;
        t_imm[i]    = im;
        t_jal[i]    = jal;
        t_taken[i]  = taken;
        t_target[i] = target;
        t_stall[i]  = stall_cycles;
        t_pred[i]   = pred;
        t_fix[i]    = fx;
    endtask

    task automatic fill_table();
        add_test(0, "jal", 18'h00040, 18'h00010, 1'b1, 1'b1, 18'h00050, 0, 1'b1, FIX_NONE);
        add_test(1, "cold_taken", 18'h00100, '0, 1'b0, 1'b1, 18'h00180, 0, 1'b0, FIX_TAKEN);
        add_test(2, "cold_not_taken", 18'h00104, '0, 1'b0, 1'b0, '0, 0, 1'b0, FIX_NONE);
        // pc index 30 hashes to 28 27 21 9 17 and then stays at 1
        add_test(3, "train_1", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(4, "train_2", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(5, "train_3", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(6, "train_4", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(7, "train_5", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(8, "train_6", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        add_test(9, "train_7", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b0, FIX_TAKEN);
        // counter 1 now at 2 and history all ones
        add_test(10, "train_8", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b1, FIX_NONE);
        add_test(11, "train_9", 18'h0013e, '0, 1'b0, 1'b1, 18'h00200, 0, 1'b1, FIX_NONE);
        add_test(12, "wrong_target", 18'h0013e, '0, 1'b0, 1'b1, 18'h00240, 0, 1'b1, FIX_TARGET);
        add_test(13, "wrong_dir", 18'h0013e, '0, 1'b0, 1'b0, 18'h00240, 0, 1'b1, FIX_NOT_TAKEN);
        // history low bits 11110 hash to index 0 with counter 1
        add_test(14, "stall", 18'h0013e, '0, 1'b0, 1'b1, 18'h00300, 3, 1'b0, FIX_TAKEN);
    endtask

    task automatic close_test();
        test_end = 1'b1;
        @(posedge clk);
        #10;
        test_end = 1'b0;
    endtask

    task automatic run_test(input int i);
        int adv;
        int waited;
        int stall_cnt;
        cur_name       = t_name[i];
        cur_ready      = 1'b1;
        cur_jal        = t_jal[i];
        cur_pred       = t_pred[i];
        cur_pc         = t_pc[i];
        cur_target     = t_target[i];
        cur_fix        = t_fix[i];
        fetch_valid    = 1'b1;
        is_branch      = ~t_jal[i];
        is_jal         = t_jal[i];
        pc             = t_pc[i];
        imm            = t_imm[i];
        resolve_taken  = t_taken[i];
        resolve_target = t_target[i];
        chk_pred       = 1'b1;
        @(posedge clk);
        #10;
        fetch_valid = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        chk_pred    = 1'b0;
        // accept edge counts as the first advance
        adv       = 1;
        waited    = 0;
        // hold the entry in decode first, execute must stay empty
        stall_cnt = t_stall[i];
        stall     = (stall_cnt > 0);
        chk_idle  = stall;
        while (adv < 2 && !timed_out) begin
            @(posedge clk);
            if (!stall) begin
                adv++;
            end
            #10;
            if (stall_cnt > 0) begin
                stall_cnt--;
            end
            stall    = (stall_cnt > 0);
            chk_idle = stall;
            waited++;
            if (adv < 2 && waited > 8) begin
                $display("timeout: test %0s never reached the execute stage", t_name[i]);
                timed_out = 1'b1;
            end
        end
        chk_fix = 1'b1;
        stall   = (t_stall[i] > 0);
        for (int s = 0; s < t_stall[i]; s++) begin
            @(posedge clk);
            #10;
        end
        stall = 1'b0;
        // training happens at the retire edge
        @(posedge clk);
        #10;
        chk_fix = 1'b0;
        close_test();
    endtask

    initial begin
        int waited;
        int chk_errs;
        clk            = 1'b0;
        rst            = 1'b1;
        stall          = 1'b0;
        fetch_valid    = 1'b0;
        is_branch      = 1'b0;
        is_jal         = 1'b0;
        pc             = '0;
        imm            = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        chk_pred       = 1'b0;
        chk_fix        = 1'b0;
        chk_idle       = 1'b0;
        test_end       = 1'b0;
        cur_name       = '0;
        cur_ready      = 1'b0;
        cur_jal        = 1'b0;
        cur_pred       = 1'b0;
        cur_pc         = '0;
        cur_target     = '0;
        cur_fix        = FIX_NONE;
        timed_out      = 1'b0;
        fill_table();
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // a branch offered while the tables are still clearing
        cur_name    = "init_gating";
        cur_pc      = 18'h0013e;
        fetch_valid = 1'b1;
        is_branch   = 1'b1;
        pc          = 18'h0013e;
        chk_pred    = 1'b1;
        @(posedge clk);
        #10;
        fetch_valid = 1'b0;
        is_branch   = 1'b0;
        chk_pred    = 1'b0;
        close_test();

        waited = 0;
        while (!ready && !timed_out) begin
            @(posedge clk);
            #10;
            waited++;
            if (!ready && waited > 64) begin
                $display("timeout: ready_o did not rise after reset");
                timed_out = 1'b1;
            end
        end

        for (int i = 0; i < N_TESTS; i++) begin
            if (!timed_out) begin
                run_test(i);
            end
        end

        @(posedge clk);
        // failures of the bound assertions
        chk_errs = branch_predictor_i.resolve_pipe_i.chk_i.err_cnt;
        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 pass_cnt, fail_cnt, chk_errs);
        if (fail_cnt == 0 && chk_errs == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
